//--- sources.f
+incdir+src
src/gcu_pkg.sv
src/vram_port_if.sv
src/host_bus_ctrl.sv
src/scroll_reg_file.sv
src/video_timing.sv
src/vram_arbiter.sv
src/vram_store.sv
src/gcu_top.sv
verification/gcu_asserts.sv
verification/gcu_tb.sv

//--- verification/gcu_tb.sv
`include "gcu_macros.svh"

module gcu_tb;

    localparam int OP_RD_L   = 0;
    localparam int OP_RD_H   = 1;
    localparam int OP_WR_RAM = 2;
    localparam int OP_PTR    = 3;
    localparam int OP_WR_REG = 4;
    localparam int OP_SEL    = 5;
    localparam int WAIT_MAX  = 200;

    logic                  CLK96;
    logic                  RESET96;
    logic [5:0]            ops;
    gcu_pkg::word_t        din;
    gcu_pkg::beam_t        h, v, hs_start, hs_end, vs_start, vs_end;
    logic                  layer_req;
    gcu_pkg::vaddr_t       layer_addr;
    gcu_pkg::word_t        dout, layer_data;
    logic                  ack, vint, hsync, vsync, fblank, layer_valid;
    gcu_pkg::scroll_bank_t scroll;

    // reference model of the chip state
    gcu_pkg::word_t        model_mem [0:(1 << `GCU_VADDR_W)-1];
    logic [15:0]           model_ptr;
    gcu_pkg::scroll_bank_t model_scroll;
    gcu_pkg::reg_sel_t     model_sel;
    logic                  model_vint;

    logic [31:0]           main_state;
    logic [31:0]           rnd_state;
    logic                  rnd_on;
    logic                  rnd_done;
    int                    rnd_wait;
    gcu_pkg::vaddr_t       safe_q [$];
    gcu_pkg::vaddr_t       pend_q [$];

    gcu_top u_gcu_top (
        .CLK96 (CLK96), .RESET96 (RESET96),
        .op_select_reg (ops[OP_SEL]), .op_write_reg (ops[OP_WR_REG]),
        .op_set_ram_ptr (ops[OP_PTR]), .op_write_ram (ops[OP_WR_RAM]),
        .op_read_ram_h (ops[OP_RD_H]), .op_read_ram_l (ops[OP_RD_L]),
        .din (din), .h (h), .v (v),
        .hs_start (hs_start), .hs_end (hs_end), .vs_start (vs_start), .vs_end (vs_end),
        .layer_req (layer_req), .layer_addr (layer_addr),
        .dout (dout), .ack (ack), .vint (vint), .hsync (hsync), .vsync (vsync),
        .fblank (fblank), .scroll (scroll),
        .layer_data (layer_data), .layer_valid (layer_valid)
    );

    initial begin
        CLK96 = 1'b0;
        forever begin
            #10 CLK96 = ~CLK96;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] draw();
        main_state = xorshift32(main_state);
        return main_state;
    endfunction

    // word that a read returns at the pointer or one past it in the 8K space
    function automatic gcu_pkg::word_t expected_read(input logic [15:0] ptr, input logic low);
        gcu_pkg::vaddr_t a;
        a = ptr[`GCU_VADDR_W-1:0] + low;
        return model_mem[a];
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic expect_equal(input string name, input logic [127:0] got,
                                input logic [127:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("error at %0t: %s is %0h, expected %0h",
                                $time, name, got, exp));
        end
    endtask

    // hold one level until ack is back and then idle for a cycle
    task automatic run_op(input int idx, input gcu_pkg::word_t data);
        int n;
        n        = 0;
        ops      = '0;
        ops[idx] = 1'b1;
        din      = data;
        @(negedge CLK96);
        if (idx <= OP_WR_RAM) begin
            expect_equal("ack", ack, 1'b0);
            while (!ack) begin
                n++;
                if (n > WAIT_MAX) begin
                    abort_run("ack did not return after a video RAM access");
                end
                @(negedge CLK96);
            end
        end
        ops = '0;
        @(negedge CLK96);
    endtask

    task automatic write_burst(input logic [15:0] base, input int len);
        logic [31:0] r;
        run_op(OP_PTR, base);
        model_ptr = base;
        for (int i = 0; i < len; i++) begin
            r = draw();
            run_op(OP_WR_RAM, r[15:0]);
            model_mem[model_ptr[`GCU_VADDR_W-1:0]] = r[15:0];
            model_ptr = model_ptr + 16'd1;
        end
    endtask

    task automatic read_back(input logic [15:0] base, input int len);
        for (int i = 0; i < len; i++) begin
            model_ptr = base + i[15:0];
            run_op(OP_PTR, model_ptr);
            run_op(OP_RD_H, 16'h0000);
            expect_equal("dout", dout, expected_read(model_ptr, 1'b0));
            if (i < len - 1) begin
                run_op(OP_RD_L, 16'h0000);
                expect_equal("dout", dout, expected_read(model_ptr, 1'b1));
            end
        end
    endtask

    // sync is low inside its window and blanking while either sync is low
    task automatic check_sync();
        logic h_in;
        logic v_in;
        h_in = (h > hs_start) && (h < hs_end);
        v_in = (v >= vs_start) && (v <= vs_end);
        expect_equal("hsync", hsync, !h_in);
        expect_equal("vsync", vsync, !v_in);
        expect_equal("fblank", fblank, !(h_in || v_in));
    endtask

    // renderer issues random reads from words that are not being written
    always @(negedge CLK96) begin
        if (rnd_done) begin
            // req drops in the cycle after rvalid
            layer_req = 1'b0;
            rnd_done  = 1'b0;
            rnd_wait  = 0;
        end else if (layer_req) begin
            rnd_wait++;
            if (layer_valid) begin
                rnd_done = 1'b1;
            end else if (rnd_wait > WAIT_MAX) begin
                abort_run("renderer read got no layer_valid");
            end
        end else if (rnd_on && safe_q.size() > 0) begin
            rnd_state = xorshift32(rnd_state);
            if (rnd_state[0]) begin
                layer_addr = safe_q[rnd_state[31:16] % safe_q.size()];
                pend_q.push_back(layer_addr);
                layer_req = 1'b1;
            end
        end
    end

    // compare renderer data against the model
    always @(negedge CLK96) begin
        if (u_gcu_top.u_vram_arbiter.u_arb_asserts.fail_count != 0) begin
            abort_run("an arbiter assertion failed");
        end
        if (layer_valid) begin
            if (pend_q.size() == 0) begin
                abort_run("layer_valid arrived with no renderer read pending");
            end else begin
                expect_equal("layer_data", layer_data,
                             expected_read({3'b000, pend_q.pop_front()}, 1'b0));
            end
        end
    end

    initial begin
        logic [31:0] r;
        logic [15:0] base;
        int          n;
        main_state   = 32'hb8e;
        rnd_state    = xorshift32(~32'hb8e);
        RESET96      = 1'b1;
        ops          = '0;
        din          = '0;
        h            = '0;
        v            = '0;
        hs_start     = '0;
        hs_end       = '0;
        vs_start     = '0;
        vs_end       = '0;
        layer_req    = 1'b0;
        layer_addr   = '0;
        model_ptr    = '0;
        model_scroll = '0;
        model_sel    = '0;
        model_vint   = 1'b1;
        rnd_on       = 1'b0;
        rnd_done     = 1'b0;
        rnd_wait     = 0;
        repeat (8) @(posedge CLK96);
        @(negedge CLK96);
        RESET96 = 1'b0;

        expect_equal("ack", ack, 1'b1);
        expect_equal("vint", vint, 1'b1);
        expect_equal("scroll", scroll, '0);
        expect_equal("layer_valid", layer_valid, 1'b0);

        // selections n and n|0x80 reach scroll entry n
        for (int i = 0; i < 32; i++) begin
            r = draw();
            run_op(OP_SEL, r[15:0]);
            model_sel = r[7:0] & 8'h8F;
            run_op(OP_WR_REG, r[31:16]);
            if (model_sel[6:0] < 7'd8) begin
                model_scroll[model_sel[2:0]] = r[31:16];
            end
            expect_equal("scroll", scroll, model_scroll);
        end

        // burst across the top of the 8K space first
        write_burst(16'hFFFC, 8);
        read_back(16'hFFFC, 8);
        for (int i = 0; i < 8; i++) begin
            safe_q.push_back(13'h1FFC + i[12:0]);
        end
        rnd_on = 1'b1;
        r      = draw();
        base   = {r[15:13], 13'h0100 + {2'b00, r[10:0]}};
        write_burst(base, 24);
        read_back(base, 24);
        for (int i = 0; i < 24; i++) begin
            safe_q.push_back(base[12:0] + i[12:0]);
        end
        write_burst(base + 16'h1000, 24);
        read_back(base + 16'h1000, 24);
        rnd_on = 1'b0;
        n      = 0;
        while (layer_req || pend_q.size() != 0) begin
            n++;
            if (n > WAIT_MAX) begin
                abort_run("renderer reads did not drain");
            end
            @(negedge CLK96);
        end

        // vint falls on the interrupt line and stays low until acknowledged
        run_op(OP_SEL, 16'h0001);
        expect_equal("vint", vint, model_vint);
        v          = `GCU_VINT_LINE;
        model_vint = 1'b0;
        @(negedge CLK96);
        expect_equal("vint", vint, model_vint);
        v = '0;
        @(negedge CLK96);
        expect_equal("vint", vint, model_vint);
        r = draw();
        run_op(OP_SEL, {r[15:8], (r[1:0] == 2'd0) ? 8'h0E : (r[1:0] == 2'd1) ? 8'h0F : 8'h8F});
        model_vint = 1'b1;
        expect_equal("vint", vint, model_vint);

        for (int i = 0; i < 64; i++) begin
            r        = draw();
            h        = r[8:0];
            v        = r[17:9];
            hs_start = r[26:18];
            r        = draw();
            hs_end   = r[8:0];
            vs_start = r[17:9];
            vs_end   = r[26:18];
            @(posedge CLK96);
            check_sync();
            @(negedge CLK96);
        end

        if (u_gcu_top.u_vram_arbiter.u_arb_asserts.fail_count != 0) begin
            abort_run("arbiter assertion failures were reported");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

//--- verification/gcu_asserts.sv
module gcu_asserts (
    input logic            CLK96,
    input logic            RESET96,
    input logic            cpu_req,
    input logic            cpu_we,
    input gcu_pkg::vaddr_t cpu_addr,
    input gcu_pkg::word_t  cpu_wdata,
    input logic            cpu_rvalid,
    input logic            rnd_req,
    input logic            rnd_rvalid,
    input logic            mem_req
);

    int unsigned fail_count = 0;
    logic        owed;

    // each grant owes exactly one rvalid
    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            owed <= 1'b0;
        end else if (mem_req) begin
            owed <= 1'b1;
        end else if (cpu_rvalid || rnd_rvalid) begin
            owed <= 1'b0;
        end
    end

    cpu_hold: assert property (@(posedge CLK96) disable iff (RESET96)
        cpu_req && !cpu_rvalid |=>
            cpu_req && $stable(cpu_we) && $stable(cpu_addr) && $stable(cpu_wdata))
        else begin
            fail_count++;
            $error("cpu request dropped or changed before its rvalid");
        end

    // rvalid only reaches the requester that waits for it
    one_owner: assert property (@(posedge CLK96) disable iff (RESET96)
        (!cpu_rvalid || cpu_req) && (!rnd_rvalid || rnd_req))
        else begin
            fail_count++;
            $error("rvalid sent to a requester with no open request");
        end

    one_per_grant: assert property (@(posedge CLK96) disable iff (RESET96)
        (cpu_rvalid || rnd_rvalid) |-> owed)
        else begin
            fail_count++;
            $error("rvalid without an open grant");
        end

endmodule

bind vram_arbiter gcu_asserts u_arb_asserts (
    .CLK96      (CLK96),
    .RESET96    (RESET96),
    .cpu_req    (cpu_port.req),
    .cpu_we     (cpu_port.we),
    .cpu_addr   (cpu_port.addr),
    .cpu_wdata  (cpu_port.wdata),
    .cpu_rvalid (cpu_port.rvalid),
    .rnd_req    (rnd_port.req),
    .rnd_rvalid (rnd_port.rvalid),
    .mem_req    (mem_port.req)
);

//--- src/gcu_top.sv
module gcu_top (
    input  logic                  CLK96,
    input  logic                  RESET96,
    input  logic                  op_select_reg,
    input  logic                  op_write_reg,
    input  logic                  op_set_ram_ptr,
    input  logic                  op_write_ram,
    input  logic                  op_read_ram_h,
    input  logic                  op_read_ram_l,
    input  gcu_pkg::word_t        din,
    input  gcu_pkg::beam_t        h,
    input  gcu_pkg::beam_t        v,
    input  gcu_pkg::beam_t        hs_start,
    input  gcu_pkg::beam_t        hs_end,
    input  gcu_pkg::beam_t        vs_start,
    input  gcu_pkg::beam_t        vs_end,
    input  logic                  layer_req,
    input  gcu_pkg::vaddr_t       layer_addr,
    output gcu_pkg::word_t        dout,
    output logic                  ack,
    output logic                  vint,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  fblank,
    output gcu_pkg::scroll_bank_t scroll,
    output gcu_pkg::word_t        layer_data,
    output logic                  layer_valid
);

    gcu_pkg::host_op_t host_op;
    logic              irq_ack_sel;

    vram_port_if cpu_port (.CLK96(CLK96));
    vram_port_if rnd_port (.CLK96(CLK96));
    vram_port_if mem_port (.CLK96(CLK96));

    assign host_op = '{
        select_reg:  op_select_reg,
        write_reg:   op_write_reg,
        set_ram_ptr: op_set_ram_ptr,
        write_ram:   op_write_ram,
        read_ram_h:  op_read_ram_h,
        read_ram_l:  op_read_ram_l
    };

    // renderer read port
    assign rnd_port.req  = layer_req;
    assign rnd_port.addr = layer_addr;
    assign layer_data    = rnd_port.rdata;
    assign layer_valid   = rnd_port.rvalid;

    host_bus_ctrl u_host_bus_ctrl (
        .CLK96    (CLK96),
        .RESET96  (RESET96),
        .op       (host_op),
        .din      (din),
        .dout     (dout),
        .ack      (ack),
        .cpu_port (cpu_port.requester)
    );

    scroll_reg_file u_scroll_reg_file (
        .CLK96         (CLK96),
        .RESET96       (RESET96),
        .op_select_reg (op_select_reg),
        .op_write_reg  (op_write_reg),
        .din           (din),
        .scroll        (scroll),
        .irq_ack_sel   (irq_ack_sel)
    );

    video_timing u_video_timing (
        .CLK96       (CLK96),
        .RESET96     (RESET96),
        .h           (h),
        .v           (v),
        .hs_start    (hs_start),
        .hs_end      (hs_end),
        .vs_start    (vs_start),
        .vs_end      (vs_end),
        .irq_ack_sel (irq_ack_sel),
        .hsync       (hsync),
        .vsync       (vsync),
        .fblank      (fblank),
        .vint        (vint)
    );

    vram_arbiter u_vram_arbiter (
        .CLK96    (CLK96),
        .RESET96  (RESET96),
        .cpu_port (cpu_port.arbiter),
        .rnd_port (rnd_port.arbiter),
        .mem_port (mem_port.requester)
    );

    vram_store u_vram_store (
        .CLK96    (CLK96),
        .mem_port (mem_port.store)
    );

endmodule

//--- src/vram_store.sv
`include "gcu_macros.svh"

module vram_store (
    input logic        CLK96,
    vram_port_if.store mem_port
);

    // 8K words, single port
    gcu_pkg::word_t mem [0:(1 << `GCU_VADDR_W)-1];

    always_ff @(posedge CLK96) begin
        if (mem_port.req && mem_port.we) begin
            mem[mem_port.addr] <= mem_port.wdata;
        end
        // read first, a write returns the old word
        mem_port.rdata  <= mem[mem_port.addr];
        mem_port.rvalid <= mem_port.req;
    end

endmodule

//--- src/vram_arbiter.sv
module vram_arbiter (
    input  logic           CLK96,
    input  logic           RESET96,
    vram_port_if.arbiter   cpu_port,
    vram_port_if.arbiter   rnd_port,
    vram_port_if.requester mem_port
);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_ISSUE,
        ARB_WAIT
    } arb_state_t;

    arb_state_t     state;
    logic           last_rnd;
    logic           pick_rnd;
    logic           ret_valid;
    gcu_pkg::word_t ret_data;

    // round robin where the renderer loses a tie if it won last time
    assign pick_rnd = rnd_port.req && (!cpu_port.req || !last_rnd);

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            state        <= ARB_IDLE;
            last_rnd     <= 1'b0;
            ret_valid    <= 1'b0;
            mem_port.req <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (cpu_port.req || rnd_port.req) begin
                        last_rnd     <= pick_rnd;
                        mem_port.req <= 1'b1;
                        state        <= ARB_ISSUE;
                    end
                end
                ARB_ISSUE: begin
                    mem_port.req <= 1'b0;
                    state        <= ARB_WAIT;
                end
                default: begin
                    // one cycle of rvalid before the owner updates req
                    if (ret_valid) begin
                        ret_valid <= 1'b0;
                        state     <= ARB_IDLE;
                    end else if (mem_port.rvalid) begin
                        ret_valid <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK96) begin
        if (state == ARB_IDLE) begin
            // renderer never writes
            mem_port.we    <= !pick_rnd && cpu_port.we;
            mem_port.addr  <= pick_rnd ? rnd_port.addr : cpu_port.addr;
            mem_port.wdata <= cpu_port.wdata;
        end
        if (mem_port.rvalid) begin
            ret_data <= mem_port.rdata;
        end
    end

    // the last grant is also the owner of the access in flight
    assign cpu_port.rvalid = ret_valid && !last_rnd;
    assign rnd_port.rvalid = ret_valid && last_rnd;
    assign cpu_port.rdata  = ret_data;
    assign rnd_port.rdata  = ret_data;

endmodule

//--- src/video_timing.sv
`include "gcu_macros.svh"

module video_timing (
    input  logic            CLK96,
    input  logic            RESET96,
    input  gcu_pkg::beam_t  h,
    input  gcu_pkg::beam_t  v,
    input  gcu_pkg::beam_t  hs_start,
    input  gcu_pkg::beam_t  hs_end,
    input  gcu_pkg::beam_t  vs_start,
    input  gcu_pkg::beam_t  vs_end,
    input  logic            irq_ack_sel,
    output logic            hsync,
    output logic            vsync,
    output logic            fblank,
    output logic            vint
);

    // open interval on h, closed on v
    assign hsync  = !((h > hs_start) && (h < hs_end));
    assign vsync  = !((v >= vs_start) && (v <= vs_end));
    assign fblank = hsync && vsync;

    // active low, the acknowledge beats the line match
    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            vint <= 1'b1;
        end else if (irq_ack_sel) begin
            vint <= 1'b1;
        end else if (v == gcu_pkg::beam_t'(`GCU_VINT_LINE)) begin
            vint <= 1'b0;
        end
    end

endmodule

//--- src/scroll_reg_file.sv
`include "gcu_macros.svh"

module scroll_reg_file (
    input  logic                  CLK96,
    input  logic                  RESET96,
    input  logic                  op_select_reg,
    input  logic                  op_write_reg,
    input  gcu_pkg::word_t        din,
    output gcu_pkg::scroll_bank_t scroll,
    output logic                  irq_ack_sel
);

    localparam int IDX_W = $clog2(`GCU_NUM_SCROLL);

    gcu_pkg::reg_sel_t reg_sel;
    logic [6:0]        reg_num;

    // bit 7 selects an alias of the same register
    assign reg_num = reg_sel[6:0];

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            reg_sel <= '0;
            scroll  <= '0;
        end else if (op_select_reg) begin
            reg_sel <= din[7:0] & `GCU_REG_MASK;
        end else if (op_write_reg) begin
            // selections past the scroll bank are dropped
            if (reg_num < `GCU_NUM_SCROLL) begin
                scroll[reg_num[IDX_W-1:0]] <= din;
            end
        end
    end

    // level, stays up while an ack register is selected
    assign irq_ack_sel = (reg_sel == `GCU_REG_IRQ_ACK_A) ||
                         (reg_sel == `GCU_REG_IRQ_ACK_B) ||
                         (reg_sel == `GCU_REG_IRQ_ACK_C);

endmodule

//--- src/host_bus_ctrl.sv
`include "gcu_macros.svh"

module host_bus_ctrl (
    input  logic                CLK96,
    input  logic                RESET96,
    input  gcu_pkg::host_op_t   op,
    input  gcu_pkg::word_t      din,
    output gcu_pkg::word_t      dout,
    output logic                ack,
    vram_port_if.requester      cpu_port
);

    logic [`GCU_PTR_W-1:0] ram_ptr;
    gcu_pkg::host_op_t     last_op;
    gcu_pkg::vaddr_t       ptr_addr;
    logic                  busy;
    logic                  is_new;
    logic                  start_wr;
    logic                  start_rd;

    // only the low bits of the pointer reach the ram
    assign ptr_addr = gcu_pkg::vaddr_t'(ram_ptr);

    // an operation is served once, until the level changes
    assign is_new   = !busy && (op != last_op);
    assign start_wr = is_new && op.write_ram;
    assign start_rd = is_new && (op.read_ram_h || op.read_ram_l);

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            busy         <= 1'b0;
            last_op      <= '0;
            ack          <= 1'b1;
            dout         <= '0;
            ram_ptr      <= '0;
            cpu_port.req <= 1'b0;
        end else if (busy) begin
            // hold the request until the arbiter answers
            if (cpu_port.rvalid) begin
                busy         <= 1'b0;
                ack          <= 1'b1;
                cpu_port.req <= 1'b0;
                if (cpu_port.we) begin
                    ram_ptr <= ram_ptr + 1'b1;
                end else begin
                    dout <= cpu_port.rdata;
                end
            end
        end else begin
            last_op <= op;
            if (is_new && op.set_ram_ptr) begin
                ram_ptr <= din;
            end
            if (start_wr || start_rd) begin
                busy         <= 1'b1;
                ack          <= 1'b0;
                cpu_port.req <= 1'b1;
            end
        end
    end

    // access fields, stable while req is up
    always_ff @(posedge CLK96) begin
        if (start_wr || start_rd) begin
            cpu_port.we    <= start_wr;
            cpu_port.wdata <= din;
            // read low looks one word ahead, wrapping in the 8K space
            if (start_rd && op.read_ram_l) begin
                cpu_port.addr <= ptr_addr + 1'b1;
            end else begin
                cpu_port.addr <= ptr_addr;
            end
        end
    end

endmodule

//--- src/vram_port_if.sv
interface vram_port_if (
    input logic CLK96
);

    logic            req;
    logic            we;
    gcu_pkg::vaddr_t addr;
    gcu_pkg::word_t  wdata;
    gcu_pkg::word_t  rdata;
    logic            rvalid;

    // full access, reads and writes
    modport requester (input CLK96, output req, we, addr, wdata, input rdata, rvalid);

    // read only client such as the tile renderer
    modport reader (input CLK96, output req, addr, input rdata, rvalid);

    modport arbiter (input CLK96, input req, we, addr, wdata, output rdata, rvalid);

    // memory side of the arbiter
    modport store (input CLK96, input req, we, addr, wdata, output rdata, rvalid);

endinterface

//--- src/gcu_pkg.sv
`include "gcu_macros.svh"

package gcu_pkg;

    typedef logic [`GCU_DATA_W-1:0]  word_t;
    typedef logic [`GCU_VADDR_W-1:0] vaddr_t;
    typedef logic [`GCU_BEAM_W-1:0]  beam_t;

    // control register number after masking
    typedef logic [7:0] reg_sel_t;

    // index order is bg x, bg y, fg x, fg y, text x, text y, sprite x, sprite y
    typedef word_t [`GCU_NUM_SCROLL-1:0] scroll_bank_t;

    // one level per cpu operation, only one is high at a time
    typedef struct packed {
        logic select_reg;
        logic write_reg;
        logic set_ram_ptr;
        logic write_ram;
        logic read_ram_h;
        logic read_ram_l;
    } host_op_t;

endpackage

//--- src/gcu_macros.svh
`ifndef GCU_MACROS_SVH
`define GCU_MACROS_SVH

// bus and memory widths
`define GCU_DATA_W   16
`define GCU_VADDR_W  13
`define GCU_PTR_W    16

// beam counters from the video timing chain
`define GCU_BEAM_W   9

// register select keeps bit 7 and the low nibble
`define GCU_REG_MASK 8'h8F

// selections that acknowledge the vertical interrupt
`define GCU_REG_IRQ_ACK_A 8'h0E
`define GCU_REG_IRQ_ACK_B 8'h0F
`define GCU_REG_IRQ_ACK_C 8'h8F

// line where vint falls
`define GCU_VINT_LINE 230

// one x and one y per layer
`define GCU_NUM_SCROLL 8

`endif
